//--- source/xpu_rx_pkg.sv
// types of the received 802.11 mac header as seen by parser and filter
// frame type codes follow the frame control type field
`default_nettype none

package xpu_rx_pkg;

    typedef logic [47:0] mac_addr_t;

    // 15:0 frame control, 31:16 duration
    // type in 3:2, subtype in 7:4
    typedef logic [31:0] fc_di_t;

    typedef logic [1:0] frame_type_t;

    localparam frame_type_t FT_MGMT = 2'd0;
    localparam frame_type_t FT_CTRL = 2'd1;
    localparam frame_type_t FT_DATA = 2'd2;

    localparam mac_addr_t BCAST_ADDR = 48'hffff_ffff_ffff;

    // each valid is a one-cycle strobe, data held until next packet
    typedef struct packed {
        fc_di_t    fc_di;
        logic      fc_valid;
        mac_addr_t addr1;
        logic      addr1_valid;
        mac_addr_t addr2;
        logic      addr2_valid;
        mac_addr_t addr3;
        logic      addr3_valid;
    } hdr_fields_t;

    // byte index that completes each field
    localparam int unsigned FC_LAST_BYTE    = 3;
    localparam int unsigned ADDR1_LAST_BYTE = 9;
    localparam int unsigned ADDR2_LAST_BYTE = 15;
    localparam int unsigned ADDR3_LAST_BYTE = 21;

endpackage

`default_nettype wire

//--- source/xpu_cfg_pkg.sv
// register map, host register port and decoded configuration of the lite xpu
// shared by the register bank, the receive filter and the top level
`default_nettype none

package xpu_cfg_pkg;

    // register port words
    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // one-cycle strobes, never high together
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        reg_addr_t addr;
        reg_data_t data;
    } reg_req_t;

    typedef struct packed {
        logic      rd_valid;
        reg_data_t data;
    } reg_rsp_t;

    // register indices
    localparam reg_addr_t REG_TSF_LOAD_LO = 6'd2;
    localparam reg_addr_t REG_TSF_LOAD_HI = 6'd3;   // bit 31 rising edge loads
    localparam reg_addr_t REG_BAND_CHAN   = 6'd4;   // 24 erp short slot, 19:16 band
    localparam reg_addr_t REG_TIMING_OVR  = 6'd9;   // 31 enable, 18:14 slot, 13:7 sifs
    localparam reg_addr_t REG_FILTER_CFG  = 6'd27;  // 0 enable, 1 drop ctrl, 2 accept all
    localparam reg_addr_t REG_MAC_LO      = 6'd30;
    localparam reg_addr_t REG_MAC_HI      = 6'd31;  // 15:0 only
    localparam reg_addr_t REG_TSF_LO      = 6'd58;  // read only
    localparam reg_addr_t REG_TSF_HI      = 6'd59;  // read only

    // decoded widths
    typedef logic [3:0]  band_t;
    typedef logic [15:0] chan_t;
    typedef logic [4:0]  slot_time_t;
    typedef logic [6:0]  sifs_time_t;
    typedef logic [63:0] tsf_val_t;

    localparam band_t BAND_2G4 = 4'd1;

    // default times in us, per band
    localparam slot_time_t SLOT_SHORT = 5'd9;
    localparam slot_time_t SLOT_LONG  = 5'd20;
    localparam sifs_time_t SIFS_2G4   = 7'd10;
    localparam sifs_time_t SIFS_5G    = 7'd16;

    typedef struct packed {
        band_t                 band;
        chan_t                 channel;
        slot_time_t            slot_time;
        sifs_time_t            sifs_time;
        logic                  filter_en;
        logic                  drop_ctrl;
        logic                  accept_all;
        xpu_rx_pkg::mac_addr_t mac_addr;
    } xpu_cfg_t;

endpackage

`default_nettype wire

//--- source/xpu_reg_bank.sv
// host register bank with single cycle strobes, registered readback
// decodes band, channel, slot/sifs time, filter flags and own mac address
`timescale 1ns/100ps
`default_nettype none

module xpu_reg_bank (
    input  wire                   clk,
    input  wire                   reset_i,
    input  xpu_cfg_pkg::reg_req_t reg_req_i,
    output xpu_cfg_pkg::reg_rsp_t reg_rsp_o,
    input  xpu_cfg_pkg::tsf_val_t tsf_i,
    output xpu_cfg_pkg::xpu_cfg_t cfg_o,
    output logic                  tsf_load_o,
    output xpu_cfg_pkg::tsf_val_t tsf_load_val_o
);

    // writable registers
    xpu_cfg_pkg::reg_data_t tsf_load_lo_q;
    xpu_cfg_pkg::reg_data_t tsf_load_hi_q;
    xpu_cfg_pkg::reg_data_t band_chan_q;
    xpu_cfg_pkg::reg_data_t timing_ovr_q;
    xpu_cfg_pkg::reg_data_t filter_cfg_q;
    xpu_cfg_pkg::reg_data_t mac_lo_q;
    xpu_cfg_pkg::reg_data_t mac_hi_q;

    xpu_cfg_pkg::reg_data_t rd_data;
    logic                   load_edge;

    // msb of load hi going 0 -> 1
    assign load_edge = reg_req_i.wr_en && (reg_req_i.addr == xpu_cfg_pkg::REG_TSF_LOAD_HI)
                       && reg_req_i.data[31] && !tsf_load_hi_q[31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tsf_load_lo_q <= '0;
            tsf_load_hi_q <= '0;
            band_chan_q   <= '0;
            timing_ovr_q  <= '0;
            filter_cfg_q  <= '0;
            mac_lo_q      <= '0;
            mac_hi_q      <= '0;
            tsf_load_o    <= 1'b0;
        end else begin
            tsf_load_o <= load_edge;
            if (reg_req_i.wr_en) begin
                case (reg_req_i.addr)
                    xpu_cfg_pkg::REG_TSF_LOAD_LO: tsf_load_lo_q <= reg_req_i.data;
                    xpu_cfg_pkg::REG_TSF_LOAD_HI: tsf_load_hi_q <= reg_req_i.data;
                    xpu_cfg_pkg::REG_BAND_CHAN:   band_chan_q   <= reg_req_i.data;
                    xpu_cfg_pkg::REG_TIMING_OVR:  timing_ovr_q  <= reg_req_i.data;
                    xpu_cfg_pkg::REG_FILTER_CFG:  filter_cfg_q  <= reg_req_i.data;
                    xpu_cfg_pkg::REG_MAC_LO:      mac_lo_q      <= reg_req_i.data;
                    xpu_cfg_pkg::REG_MAC_HI:      mac_hi_q      <= reg_req_i.data;
                    default: ;
                endcase
            end
        end
    end

    // strobe follows the write, so the registers already hold the new value
    assign tsf_load_val_o = {1'b0, tsf_load_hi_q[30:0], tsf_load_lo_q};

    // read mux with tsf sampled live
    always_comb begin
        case (reg_req_i.addr)
            xpu_cfg_pkg::REG_TSF_LOAD_LO: rd_data = tsf_load_lo_q;
            xpu_cfg_pkg::REG_TSF_LOAD_HI: rd_data = tsf_load_hi_q;
            xpu_cfg_pkg::REG_BAND_CHAN:   rd_data = band_chan_q;
            xpu_cfg_pkg::REG_TIMING_OVR:  rd_data = timing_ovr_q;
            xpu_cfg_pkg::REG_FILTER_CFG:  rd_data = filter_cfg_q;
            xpu_cfg_pkg::REG_MAC_LO:      rd_data = mac_lo_q;
            xpu_cfg_pkg::REG_MAC_HI:      rd_data = mac_hi_q;
            xpu_cfg_pkg::REG_TSF_LO:      rd_data = tsf_i[31:0];
            xpu_cfg_pkg::REG_TSF_HI:      rd_data = tsf_i[63:32];
            default:                      rd_data = '0;
        endcase
    end

    // response registered one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_rsp_o.rd_valid <= 1'b0;
        end else begin
            reg_rsp_o.rd_valid <= reg_req_i.rd_en;
        end
        if (reg_req_i.rd_en) begin
            reg_rsp_o.data <= rd_data;
        end
    end

    // decode
    always_comb begin
        cfg_o.band       = band_chan_q[19:16];
        cfg_o.channel    = band_chan_q[15:0];
        cfg_o.filter_en  = filter_cfg_q[0];
        cfg_o.drop_ctrl  = filter_cfg_q[1];
        cfg_o.accept_all = filter_cfg_q[2];
        cfg_o.mac_addr   = {mac_hi_q[15:0], mac_lo_q};
        if (timing_ovr_q[31]) begin
            cfg_o.slot_time = timing_ovr_q[18:14];
            cfg_o.sifs_time = timing_ovr_q[13:7];
        end else if (band_chan_q[19:16] == xpu_cfg_pkg::BAND_2G4) begin
            // erp short slot only matters on 2.4 GHz
            cfg_o.slot_time = band_chan_q[24] ? xpu_cfg_pkg::SLOT_SHORT
                                              : xpu_cfg_pkg::SLOT_LONG;
            cfg_o.sifs_time = xpu_cfg_pkg::SIFS_2G4;
        end else begin
            cfg_o.slot_time = xpu_cfg_pkg::SLOT_SHORT;
            cfg_o.sifs_time = xpu_cfg_pkg::SIFS_5G;
        end
    end

endmodule

`default_nettype wire

//--- source/tsf_timer.sv
// 64 bit tsf timer counting microseconds, with 1 MHz pulse
// loaded directly by a one-cycle strobe from the register bank
`timescale 1ns/100ps
`default_nettype none

module tsf_timer #(
    parameter int CLK_PER_US = 100
) (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   load_i,
    input  xpu_cfg_pkg::tsf_val_t load_val_i,
    output xpu_cfg_pkg::tsf_val_t tsf_o,
    output logic                  pulse_1m_o
);

    localparam int PHASE_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

    typedef logic [PHASE_W-1:0] phase_t;

    localparam phase_t PHASE_TOP = phase_t'(CLK_PER_US - 1);

    phase_t phase_q;
    logic   us_done;

    assign us_done = (phase_q == PHASE_TOP);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q    <= '0;
            tsf_o      <= '0;
            pulse_1m_o <= 1'b0;
        end else if (load_i) begin
            // phase restarts with the new value
            phase_q    <= '0;
            tsf_o      <= load_val_i;
            pulse_1m_o <= 1'b0;
        end else begin
            pulse_1m_o <= us_done;
            if (us_done) begin
                phase_q <= '0;
                tsf_o   <= tsf_o + 64'd1;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mac_hdr_parse.sv
// picks frame control, duration and addr1..3 out of the rx byte stream
// bytes land by index, little-endian per field, strobes one cycle later
`timescale 1ns/100ps
`default_nettype none

module mac_hdr_parse (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     pkt_start_i,
    input  wire                     byte_strobe_i,
    input  wire [7:0]               byte_i,
    input  wire [15:0]              byte_index_i,
    output xpu_rx_pkg::hdr_fields_t hdr_o
);

    localparam int HDR_BYTES = xpu_rx_pkg::ADDR3_LAST_BYTE + 1;

    // header bytes 0..21 with index 0 at the lsb
    logic [HDR_BYTES-1:0][7:0] hdr_q;

    logic fc_valid_q;
    logic addr1_valid_q;
    logic addr2_valid_q;
    logic addr3_valid_q;
    logic in_hdr;

    assign in_hdr = byte_strobe_i && (byte_index_i < 16'(HDR_BYTES));

    // new packet wipes old partial fields before any byte lands
    always_ff @(posedge clk) begin
        if (pkt_start_i) begin
            hdr_q <= '0;
        end else if (in_hdr) begin
            hdr_q[byte_index_i[4:0]] <= byte_i;
        end
    end

    // strobes on the last byte of each field
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fc_valid_q    <= 1'b0;
            addr1_valid_q <= 1'b0;
            addr2_valid_q <= 1'b0;
            addr3_valid_q <= 1'b0;
        end else begin
            fc_valid_q    <= byte_strobe_i
                             && (byte_index_i == 16'(xpu_rx_pkg::FC_LAST_BYTE));
            addr1_valid_q <= byte_strobe_i
                             && (byte_index_i == 16'(xpu_rx_pkg::ADDR1_LAST_BYTE));
            addr2_valid_q <= byte_strobe_i
                             && (byte_index_i == 16'(xpu_rx_pkg::ADDR2_LAST_BYTE));
            addr3_valid_q <= byte_strobe_i
                             && (byte_index_i == 16'(xpu_rx_pkg::ADDR3_LAST_BYTE));
        end
    end

    // field slices
    assign hdr_o.fc_di       = hdr_q[3:0];
    assign hdr_o.fc_valid    = fc_valid_q;
    assign hdr_o.addr1       = hdr_q[9:4];
    assign hdr_o.addr1_valid = addr1_valid_q;
    assign hdr_o.addr2       = hdr_q[15:10];
    assign hdr_o.addr2_valid = addr2_valid_q;
    assign hdr_o.addr3       = hdr_q[21:16];
    assign hdr_o.addr3_valid = addr3_valid_q;

endmodule

`default_nettype wire

//--- source/rx_pkt_filter.sv
// decides whether a received packet is kept away from rx dma
// type latched at fc_valid, decision made one cycle after addr1_valid
`timescale 1ns/100ps
`default_nettype none

module rx_pkt_filter (
    input  wire                     clk,
    input  wire                     reset_i,
    input  xpu_cfg_pkg::xpu_cfg_t   cfg_i,
    input  xpu_rx_pkg::hdr_fields_t hdr_i,
    output logic                    block_o,
    output logic                    block_valid_o
);

    xpu_rx_pkg::frame_type_t ftype_q;

    logic is_ctrl;
    logic addr_hit;
    logic block_next;

    // own address or broadcast counts as ours
    assign addr_hit = (hdr_i.addr1 == cfg_i.mac_addr)
                      || (hdr_i.addr1 == xpu_rx_pkg::BCAST_ADDR);
    assign is_ctrl  = (ftype_q == xpu_rx_pkg::FT_CTRL);

    // disabled filter never blocks
    assign block_next = cfg_i.filter_en
                        && ((is_ctrl && cfg_i.drop_ctrl) || (!addr_hit && !cfg_i.accept_all));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ftype_q <= xpu_rx_pkg::FT_MGMT;
        end else if (hdr_i.fc_valid) begin
            ftype_q <= hdr_i.fc_di[3:2];
        end
    end

    // block held until next decision
    always_ff @(posedge clk) begin
        if (reset_i) begin
            block_o       <= 1'b0;
            block_valid_o <= 1'b0;
        end else begin
            block_valid_o <= hdr_i.addr1_valid;
            if (hdr_i.addr1_valid) begin
                block_o <= block_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/xpu_lite.sv
// top of the reduced lower mac control core
// register bank, tsf timer, header parser and rx filter tied together
`timescale 1ns/100ps
`default_nettype none

module xpu_lite #(
    parameter int CLK_PER_US = 100
) (
    input  wire                       clk,
    input  wire                       reset_i,
    // host register port
    input  xpu_cfg_pkg::reg_req_t     reg_req_i,
    output xpu_cfg_pkg::reg_rsp_t     reg_rsp_o,
    // rx byte stream
    input  wire                       pkt_start_i,
    input  wire                       byte_strobe_i,
    input  wire [7:0]                 byte_i,
    input  wire [15:0]                byte_index_i,
    // decoded config
    output xpu_cfg_pkg::band_t        band_o,
    output xpu_cfg_pkg::chan_t        channel_o,
    output xpu_cfg_pkg::slot_time_t   slot_time_o,
    output xpu_cfg_pkg::sifs_time_t   sifs_time_o,
    // timer
    output xpu_cfg_pkg::tsf_val_t     tsf_o,
    output logic                      tsf_pulse_1m_o,
    // parsed header and filter result
    output xpu_rx_pkg::hdr_fields_t   hdr_o,
    output logic                      block_rx_dma_o,
    output logic                      block_rx_dma_valid_o
);

    xpu_cfg_pkg::xpu_cfg_t cfg;
    xpu_cfg_pkg::tsf_val_t tsf_load_val;
    logic                  tsf_load;

    assign band_o      = cfg.band;
    assign channel_o   = cfg.channel;
    assign slot_time_o = cfg.slot_time;
    assign sifs_time_o = cfg.sifs_time;

    xpu_reg_bank xpu_reg_bank_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_req_i      (reg_req_i),
        .reg_rsp_o      (reg_rsp_o),
        .tsf_i          (tsf_o),
        .cfg_o          (cfg),
        .tsf_load_o     (tsf_load),
        .tsf_load_val_o (tsf_load_val)
    );

    tsf_timer #(
        .CLK_PER_US (CLK_PER_US)
    ) tsf_timer_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .load_i     (tsf_load),
        .load_val_i (tsf_load_val),
        .tsf_o      (tsf_o),
        .pulse_1m_o (tsf_pulse_1m_o)
    );

    mac_hdr_parse mac_hdr_parse_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .pkt_start_i   (pkt_start_i),
        .byte_strobe_i (byte_strobe_i),
        .byte_i        (byte_i),
        .byte_index_i  (byte_index_i),
        .hdr_o         (hdr_o)
    );

    rx_pkt_filter rx_pkt_filter_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .cfg_i         (cfg),
        .hdr_i         (hdr_o),
        .block_o       (block_rx_dma_o),
        .block_valid_o (block_rx_dma_valid_o)
    );

endmodule

`default_nettype wire

//--- tb/xpu_chk.sv
// concurrent assertions on xpu_lite strobes and reset values
// attached to every xpu_lite instance through the bind below
`timescale 1ns/100ps
`default_nettype none

module xpu_chk (
    input wire                        clk,
    input wire                        reset_i,
    input wire [6:0]                  strobes_i,
    input wire                        block_i,
    input wire xpu_cfg_pkg::tsf_val_t tsf_i
);

    int assert_fails = 0;

    // no strobe stays high two cycles in a row
    one_cycle_strobes: assert property (@(posedge clk) disable iff (reset_i)
        (strobes_i & $past(strobes_i)) == '0)
        else begin
            $error("strobe output high for more than one cycle");
            assert_fails++;
        end

    // a reset edge leaves strobes, block and tsf at zero
    reset_values: assert property (@(posedge clk)
        $past(reset_i) |-> (strobes_i == '0) && !block_i && (tsf_i == '0))
        else begin
            $error("outputs not cleared by reset");
            assert_fails++;
        end

endmodule

bind xpu_lite xpu_chk xpu_chk_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .strobes_i ({reg_rsp_o.rd_valid, tsf_pulse_1m_o, hdr_o.fc_valid, hdr_o.addr1_valid,
                 hdr_o.addr2_valid, hdr_o.addr3_valid, block_rx_dma_valid_o}),
    .block_i   (block_rx_dma_o),
    .tsf_i     (tsf_o)
);

`default_nettype wire

//--- tb/xpu_scoreboard.sv
// reference model for xpu_lite, watches the dut ports and counts mismatches
// model state advances on the rising edge, outputs are compared on the falling edge
`timescale 1ns/100ps
`default_nettype none

module xpu_scoreboard #(
    parameter int CLK_PER_US = 100
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  xpu_cfg_pkg::reg_req_t   reg_req_i,
    input  xpu_cfg_pkg::reg_rsp_t   reg_rsp_o,
    input  wire                     pkt_start_i,
    input  wire                     byte_strobe_i,
    input  wire [7:0]               byte_i,
    input  wire [15:0]              byte_index_i,
    input  xpu_cfg_pkg::band_t      band_o,
    input  xpu_cfg_pkg::chan_t      channel_o,
    input  xpu_cfg_pkg::slot_time_t slot_time_o,
    input  xpu_cfg_pkg::sifs_time_t sifs_time_o,
    input  xpu_cfg_pkg::tsf_val_t   tsf_o,
    input  wire                     tsf_pulse_1m_o,
    input  xpu_rx_pkg::hdr_fields_t hdr_o,
    input  wire                     block_rx_dma_o,
    input  wire                     block_rx_dma_valid_o,
    output int                      error_count_o
);

    // shadow register file where unmapped entries stay zero
    logic [31:0]           regs [0:63];
    logic [7:0]            hdr [0:21];
    xpu_cfg_pkg::tsf_val_t exp_tsf;
    xpu_cfg_pkg::tsf_val_t load_val;
    int                    phase;
    int                    errors = 0;
    bit                    live;
    logic                  exp_pulse;
    logic                  load_pend;
    logic                  exp_rd_valid;
    logic [31:0]           exp_rd;
    logic [3:0]            exp_hv;   // addr3, addr2, addr1, fc
    logic                  exp_blk;
    logic                  exp_blk_valid;
    logic [1:0]            ftype;
    xpu_rx_pkg::mac_addr_t addr1;
    xpu_rx_pkg::mac_addr_t own;
    logic                  hit;

    assign error_count_o = errors;

    // indices 2, 3, 4, 9, 27, 30 and 31 are the writable ones
    function automatic bit writable(xpu_cfg_pkg::reg_addr_t a);
        return a inside {6'd2, 6'd3, 6'd4, 6'd9, 6'd27, 6'd30, 6'd31};
    endfunction

    function automatic logic [31:0] read_value(xpu_cfg_pkg::reg_addr_t a);
        if (a == 6'd58) return exp_tsf[31:0];
        if (a == 6'd59) return exp_tsf[63:32];
        return regs[a];
    endfunction

    // little-endian field out of the header bytes
    function automatic logic [47:0] gather_bytes(int lo, int n);
        logic [47:0] v;
        v = '0;
        for (int k = n - 1; k >= 0; k--) v = {v[39:0], hdr[lo + k]};
        return v;
    endfunction

    // slot and sifs from the band table or the override register
    function automatic logic [4:0] expected_slot();
        if (regs[9][31]) return regs[9][18:14];
        if (regs[4][19:16] == 4'd1) return regs[4][24] ? 5'd9 : 5'd20;
        return 5'd9;
    endfunction

    function automatic logic [6:0] expected_sifs();
        if (regs[9][31]) return regs[9][13:7];
        return (regs[4][19:16] == 4'd1) ? 7'd10 : 7'd16;
    endfunction

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, exp, got);
        end
    endtask

    always @(posedge clk) begin
        if (reset_i) begin
            live = 1'b1;
            foreach (regs[i]) regs[i] = '0;
            exp_tsf       = '0;
            phase         = 0;
            exp_pulse     = 1'b0;
            load_pend     = 1'b0;
            exp_rd_valid  = 1'b0;
            exp_hv        = '0;
            exp_blk       = 1'b0;
            exp_blk_valid = 1'b0;
            ftype         = 2'd0;
        end else begin
            // decision on the cycle addr1_valid is high
            if (exp_hv[1]) begin
                addr1   = gather_bytes(4, 6);
                own     = {regs[31][15:0], regs[30]};
                hit     = (addr1 == own) || (addr1 == 48'hffff_ffff_ffff);
                exp_blk = regs[27][0]
                          && ((ftype == 2'd1 && regs[27][1]) || (!hit && !regs[27][2]));
            end
            exp_blk_valid = exp_hv[1];
            if (exp_hv[0]) ftype = hdr[0][3:2];
            // read data is the value at the strobe
            exp_rd_valid = reg_req_i.rd_en;
            if (reg_req_i.rd_en) exp_rd = read_value(reg_req_i.addr);
            // load lands one cycle after the strobe and restarts the phase
            if (load_pend) begin
                exp_tsf   = load_val;
                phase     = 0;
                exp_pulse = 1'b0;
            end else begin
                phase++;
                exp_pulse = (phase == CLK_PER_US);
                if (exp_pulse) begin
                    phase = 0;
                    exp_tsf++;
                end
            end
            load_pend = reg_req_i.wr_en && (reg_req_i.addr == 6'd3)
                        && reg_req_i.data[31] && !regs[3][31];
            load_val  = {1'b0, reg_req_i.data[30:0], regs[2]};
            if (reg_req_i.wr_en && writable(reg_req_i.addr)) begin
                regs[reg_req_i.addr] = reg_req_i.data;
            end
            // field strobes one cycle after bytes 3, 9, 15, 21
            exp_hv = {4{byte_strobe_i}} & {byte_index_i == 16'd21, byte_index_i == 16'd15,
                                            byte_index_i == 16'd9, byte_index_i == 16'd3};
            if (pkt_start_i) begin
                foreach (hdr[i]) hdr[i] = '0;
            end else if (byte_strobe_i && byte_index_i < 16'd22) begin
                hdr[byte_index_i] = byte_i;
            end
        end
    end

    always @(negedge clk) begin
        if (live) begin
            compare_value("reg_rsp_o.rd_valid", reg_rsp_o.rd_valid, exp_rd_valid);
            if (exp_rd_valid) compare_value("reg_rsp_o.data", reg_rsp_o.data, exp_rd);
            compare_value("band_o", band_o, regs[4][19:16]);
            compare_value("channel_o", channel_o, regs[4][15:0]);
            compare_value("slot_time_o", slot_time_o, expected_slot());
            compare_value("sifs_time_o", sifs_time_o, expected_sifs());
            compare_value("tsf_o", tsf_o, exp_tsf);
            compare_value("tsf_pulse_1m_o", tsf_pulse_1m_o, exp_pulse);
            compare_value("hdr_o.fc_valid", hdr_o.fc_valid, exp_hv[0]);
            compare_value("hdr_o.addr1_valid", hdr_o.addr1_valid, exp_hv[1]);
            compare_value("hdr_o.addr2_valid", hdr_o.addr2_valid, exp_hv[2]);
            compare_value("hdr_o.addr3_valid", hdr_o.addr3_valid, exp_hv[3]);
            if (exp_hv[0]) compare_value("hdr_o.fc_di", hdr_o.fc_di, gather_bytes(0, 4));
            if (exp_hv[1]) compare_value("hdr_o.addr1", hdr_o.addr1, gather_bytes(4, 6));
            if (exp_hv[2]) compare_value("hdr_o.addr2", hdr_o.addr2, gather_bytes(10, 6));
            if (exp_hv[3]) compare_value("hdr_o.addr3", hdr_o.addr3, gather_bytes(16, 6));
            compare_value("block_rx_dma_valid_o", block_rx_dma_valid_o, exp_blk_valid);
            compare_value("block_rx_dma_o", block_rx_dma_o, exp_blk);
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_xpu.sv
// testbench top for xpu_lite with seeded random register, tsf and packet stimulus
// results come from xpu_scoreboard and the bound xpu_chk assertions
`timescale 1ns/100ps
`default_nettype none

module tb_xpu;

    localparam int CLK_PER_US = 10;
    localparam int N_REG_OPS  = 60;
    localparam int N_DEC_OPS  = 20;
    localparam int N_TSF_LOAD = 2;
    localparam int TSF_WAIT   = 6 * CLK_PER_US;
    localparam int N_PKTS     = 40;
    // worst case cycles of each phase with at most 60 per packet
    localparam int TEST_CYCLES = 4 + N_REG_OPS * 2 + N_DEC_OPS * 4
                                 + N_TSF_LOAD * (10 + TSF_WAIT) + 4 + N_PKTS * 60 + 4;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                    clk;
    logic                    reset_i;
    xpu_cfg_pkg::reg_req_t   reg_req_i;
    xpu_cfg_pkg::reg_rsp_t   reg_rsp_o;
    logic                    pkt_start_i;
    logic                    byte_strobe_i;
    logic [7:0]              byte_i;
    logic [15:0]             byte_index_i;
    xpu_cfg_pkg::band_t      band_o;
    xpu_cfg_pkg::chan_t      channel_o;
    xpu_cfg_pkg::slot_time_t slot_time_o;
    xpu_cfg_pkg::sifs_time_t sifs_time_o;
    xpu_cfg_pkg::tsf_val_t   tsf_o;
    logic                    tsf_pulse_1m_o;
    xpu_rx_pkg::hdr_fields_t hdr_o;
    logic                    block_rx_dma_o;
    logic                    block_rx_dma_valid_o;
    int                      error_count;
    int                      cycle_count;
    xpu_rx_pkg::mac_addr_t   own_mac;

    xpu_lite #(.CLK_PER_US(CLK_PER_US)) dut (.*);

    xpu_scoreboard #(.CLK_PER_US(CLK_PER_US)) sb (.*, .error_count_o(error_count));

    always #2 clk = ~clk;

    task automatic write_reg(input xpu_cfg_pkg::reg_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        reg_req_i.wr_en = 1'b1;
        reg_req_i.addr  = addr;
        reg_req_i.data  = data;
        @(negedge clk);
        reg_req_i.wr_en = 1'b0;
    endtask

    task automatic read_reg(input xpu_cfg_pkg::reg_addr_t addr);
        @(negedge clk);
        reg_req_i.rd_en = 1'b1;
        reg_req_i.addr  = addr;
        @(negedge clk);
        reg_req_i.rd_en = 1'b0;
    endtask

    // half mapped indices, half anywhere in the map
    function automatic xpu_cfg_pkg::reg_addr_t pick_addr();
        xpu_cfg_pkg::reg_addr_t mapped [9];
        mapped = '{6'd2, 6'd3, 6'd4, 6'd9, 6'd27, 6'd30, 6'd31, 6'd58, 6'd59};
        if ($urandom_range(1) == 1) return mapped[$urandom_range(8)];
        return 6'($urandom());
    endfunction

    task automatic send_packet();
        logic [7:0]            pkt [0:25];
        logic [31:0]           fc_di;
        xpu_rx_pkg::mac_addr_t addr1;
        int                    sel;
        int                    len;
        fc_di      = $urandom();
        fc_di[3:2] = 2'($urandom_range(3));
        sel        = $urandom_range(2);
        // own address, broadcast or a stranger
        addr1 = (sel == 0) ? own_mac : (sel == 1) ? 48'hffff_ffff_ffff
                                                  : 48'({$urandom(), $urandom()});
        len = 22 + $urandom_range(4);
        foreach (pkt[i]) pkt[i] = 8'($urandom());
        for (int k = 0; k < 4; k++) pkt[k] = fc_di[8*k +: 8];
        for (int k = 0; k < 6; k++) pkt[4 + k] = addr1[8*k +: 8];
        write_reg(xpu_cfg_pkg::REG_FILTER_CFG, 32'($urandom_range(7)));
        @(negedge clk);
        pkt_start_i = 1'b1;
        @(negedge clk);
        pkt_start_i = 1'b0;
        for (int idx = 0; idx < len; idx++) begin
            // occasional idle cycle between bytes
            if ($urandom_range(3) == 0) begin
                byte_strobe_i = 1'b0;
                @(negedge clk);
            end
            byte_strobe_i = 1'b1;
            byte_i        = pkt[idx];
            byte_index_i  = 16'(idx);
            @(negedge clk);
        end
        byte_strobe_i = 1'b0;
    endtask

    initial begin
        xpu_cfg_pkg::band_t band;
        logic [30:0]        load_hi;
        void'($urandom(32'h2e77));
        clk           = 1'b0;
        reset_i       = 1'b1;
        reg_req_i     = '0;
        pkt_start_i   = 1'b0;
        byte_strobe_i = 1'b0;
        byte_i        = '0;
        byte_index_i  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int n = 0; n < N_REG_OPS; n++) begin
            if ($urandom_range(1) == 1) write_reg(pick_addr(), $urandom());
            else read_reg(pick_addr());
        end
        // band and timing decode with 2.4 GHz half the time
        for (int n = 0; n < N_DEC_OPS; n++) begin
            band = ($urandom_range(1) == 1) ? 4'd1 : 4'($urandom());
            write_reg(xpu_cfg_pkg::REG_BAND_CHAN,
                      {7'd0, 1'($urandom()), 4'd0, band, 16'($urandom())});
            write_reg(xpu_cfg_pkg::REG_TIMING_OVR,
                      {($urandom_range(3) == 0), 12'd0, 19'($urandom())});
        end
        for (int n = 0; n < N_TSF_LOAD; n++) begin
            load_hi = 31'($urandom());
            write_reg(xpu_cfg_pkg::REG_TSF_LOAD_LO, $urandom());
            write_reg(xpu_cfg_pkg::REG_TSF_LOAD_HI, {1'b0, load_hi});
            write_reg(xpu_cfg_pkg::REG_TSF_LOAD_HI, {1'b1, load_hi});
            repeat ($urandom_range(TSF_WAIT)) @(negedge clk);
            read_reg(xpu_cfg_pkg::REG_TSF_LO);
            read_reg(xpu_cfg_pkg::REG_TSF_HI);
        end
        own_mac = 48'({$urandom(), $urandom()});
        write_reg(xpu_cfg_pkg::REG_MAC_LO, own_mac[31:0]);
        write_reg(xpu_cfg_pkg::REG_MAC_HI, {16'd0, own_mac[47:32]});
        for (int n = 0; n < N_PKTS; n++) send_packet();
        // let the last filter decision drain
        repeat (4) @(negedge clk);
        $display("errors: %0d from scoreboard, %0d from assertions",
                 error_count, dut.xpu_chk_i.assert_fails);
        if (error_count == 0 && dut.xpu_chk_i.assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/xpu_rx_pkg.sv
source/xpu_cfg_pkg.sv
source/xpu_reg_bank.sv
source/tsf_timer.sv
source/mac_hdr_parse.sv
source/rx_pkt_filter.sv
source/xpu_lite.sv
tb/xpu_chk.sv
tb/xpu_scoreboard.sv
tb/tb_xpu.sv
